// ==== include/csa_settings.svh ====
`ifndef CSA_SETTINGS_SVH
`define CSA_SETTINGS_SVH

`define CSA_UNITS 4
`define CSA_HIST_BINS 16
`define CSA_ADDR_BITS 5

// Word addresses of the register map.
`define CSA_REG_CHANNEL 5'd0
`define CSA_REG_BLOCK 5'd1
`define CSA_REG_KEY_LO 5'd2
`define CSA_REG_KEY_HI 5'd3
`define CSA_REG_ROUNDS 5'd4
`define CSA_REG_START 5'd5
`define CSA_REG_SUBMIT 5'd6
`define CSA_REG_RES_VALID 5'd7
`define CSA_REG_RES_LO 5'd8
`define CSA_REG_RES_HI 5'd9
`define CSA_REG_RES_START 5'd10
`define CSA_REG_HIST_INDEX 5'd11
`define CSA_REG_HIST_COUNT 5'd12
`define CSA_REG_MASK_LO 5'd13
`define CSA_REG_MASK_HI 5'd14
`define CSA_REG_VALUE_LO 5'd15
`define CSA_REG_VALUE_HI 5'd16
`define CSA_REG_MATCH_COUNT 5'd17
`define CSA_REG_BUSY 5'd18
`define CSA_REG_CLEAR 5'd19

`endif

// ==== logic/csa_pkg.sv ====
package csa_pkg;

	// Wishbone data word.
	typedef logic [31:0] word_t;

	// Key, result and match mask share this width.
	typedef logic [63:0] key_t;

	typedef logic [7:0] rounds_t;

	typedef logic [1:0] unit_idx_t;

	typedef logic [3:0] hist_idx_t;

	// Histogram bins and the match counter.
	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		CALC_IDLE,
		CALC_RUN,
		CALC_DONE
	} calc_state_t;

endpackage

// ==== logic/csa_ifs.sv ====
`timescale 1ns/1ps

interface csa_job_if;
	import csa_pkg::*;

	logic job_valid;
	logic job_ready;
	word_t block;
	key_t key;
	rounds_t rounds;
	word_t start;

	modport dispatch (output job_valid, block, key, rounds, start, input job_ready);
	modport unit (input job_valid, block, key, rounds, start, output job_ready);
endinterface

interface csa_result_if;
	import csa_pkg::*;

	logic res_valid;
	logic res_ack;
	key_t result;
	word_t start;

	modport unit (output res_valid, result, start, input res_ack);
	modport collect (input res_valid, result, start, output res_ack);
endinterface

interface csa_status_if;
	import csa_pkg::*;

	unit_idx_t channel;
	logic channel_wr;
	hist_idx_t hist_index;
	key_t mask;
	key_t value;
	logic clear;
	logic snap_valid;
	key_t snap_result;
	word_t snap_start;
	count_t hist_count;
	count_t match_count;

	modport regs (
		output channel, channel_wr, hist_index, mask, value, clear,
		input snap_valid, snap_result, snap_start, hist_count, match_count
	);
	modport collect (
		input channel, channel_wr, hist_index, mask, value, clear,
		output snap_valid, snap_result, snap_start, hist_count, match_count
	);
endinterface

// ==== logic/csa_regs.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_regs (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [`CSA_ADDR_BITS-1:0] wb_adr_i,
	input csa_pkg::word_t wb_dat_i,
	output csa_pkg::word_t wb_dat_o,
	output logic wb_ack_o,
	output csa_pkg::word_t job_block_o,
	output csa_pkg::key_t job_key_o,
	output csa_pkg::rounds_t job_rounds_o,
	output csa_pkg::word_t job_start_o,
	output logic submit_o,
	input logic pending_i,
	input logic busy_i,
	csa_status_if.regs status
);
	import csa_pkg::*;

	logic ack_q;
	logic wr;
	logic rd;
	logic chan_wr;
	word_t rd_data;
	word_t dat_q;
	unit_idx_t channel_q;
	hist_idx_t hist_index_q;
	key_t mask_q;
	key_t value_q;
	word_t block_q;
	key_t key_q;
	rounds_t rounds_q;
	word_t start_q;

	// First cycle of a strobe only; ack answers on the next edge.
	assign wr = wb_cyc_i && wb_stb_i && !ack_q && wb_we_i;
	assign rd = wb_cyc_i && wb_stb_i && !ack_q && !wb_we_i;

	assign chan_wr = wr && (wb_adr_i == `CSA_REG_CHANNEL) && (wb_dat_i < `CSA_UNITS);
	assign submit_o = wr && (wb_adr_i == `CSA_REG_SUBMIT);

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			channel_q <= '0;
			hist_index_q <= '0;
			mask_q <= '0;
			value_q <= '0;
		end else begin
			ack_q <= wr || rd;
			if (chan_wr)
				channel_q <= unit_idx_t'(wb_dat_i);
			if (wr) begin
				case (wb_adr_i)
					`CSA_REG_HIST_INDEX: hist_index_q <= hist_idx_t'(wb_dat_i);
					`CSA_REG_MASK_LO: mask_q[31:0] <= wb_dat_i;
					`CSA_REG_MASK_HI: mask_q[63:32] <= wb_dat_i;
					`CSA_REG_VALUE_LO: value_q[31:0] <= wb_dat_i;
					`CSA_REG_VALUE_HI: value_q[63:32] <= wb_dat_i;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (wr) begin
			case (wb_adr_i)
				`CSA_REG_BLOCK: block_q <= wb_dat_i;
				`CSA_REG_KEY_LO: key_q[31:0] <= wb_dat_i;
				`CSA_REG_KEY_HI: key_q[63:32] <= wb_dat_i;
				`CSA_REG_ROUNDS: rounds_q <= rounds_t'(wb_dat_i);
				`CSA_REG_START: start_q <= wb_dat_i;
				default: ;
			endcase
		end
		if (rd)
			dat_q <= rd_data;
	end

	always_comb begin
		case (wb_adr_i)
			`CSA_REG_CHANNEL: rd_data = {30'd0, channel_q};
			`CSA_REG_BLOCK: rd_data = block_q;
			`CSA_REG_KEY_LO: rd_data = key_q[31:0];
			`CSA_REG_KEY_HI: rd_data = key_q[63:32];
			`CSA_REG_ROUNDS: rd_data = {24'd0, rounds_q};
			`CSA_REG_START: rd_data = start_q;
			`CSA_REG_SUBMIT: rd_data = {31'd0, pending_i};
			`CSA_REG_RES_VALID: rd_data = {31'd0, status.snap_valid};
			`CSA_REG_RES_LO: rd_data = status.snap_result[31:0];
			`CSA_REG_RES_HI: rd_data = status.snap_result[63:32];
			`CSA_REG_RES_START: rd_data = status.snap_start;
			`CSA_REG_HIST_INDEX: rd_data = {28'd0, hist_index_q};
			`CSA_REG_HIST_COUNT: rd_data = status.hist_count;
			`CSA_REG_MASK_LO: rd_data = mask_q[31:0];
			`CSA_REG_MASK_HI: rd_data = mask_q[63:32];
			`CSA_REG_VALUE_LO: rd_data = value_q[31:0];
			`CSA_REG_VALUE_HI: rd_data = value_q[63:32];
			`CSA_REG_MATCH_COUNT: rd_data = status.match_count;
			`CSA_REG_BUSY: rd_data = {31'd0, busy_i};
			// Unmapped, write-only CLEAR included.
			default: rd_data = {16'hE000, {(16 - `CSA_ADDR_BITS){1'b0}}, wb_adr_i};
		endcase
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign job_block_o = block_q;
	assign job_key_o = key_q;
	assign job_rounds_o = rounds_q;
	assign job_start_o = start_q;

	assign status.channel = channel_q;
	assign status.channel_wr = chan_wr;
	assign status.hist_index = hist_index_q;
	assign status.mask = mask_q;
	assign status.value = value_q;
	assign status.clear = wr && (wb_adr_i == `CSA_REG_CLEAR);

endmodule

// ==== logic/csa_dispatch.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_dispatch (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic submit_i,
	input csa_pkg::word_t block_i,
	input csa_pkg::key_t key_i,
	input csa_pkg::rounds_t rounds_i,
	input csa_pkg::word_t start_i,
	output logic pending_o,
	csa_job_if.dispatch job [0:`CSA_UNITS-1]
);
	import csa_pkg::*;

	logic pending_q;
	logic offer_q;
	unit_idx_t ptr_q;
	logic [`CSA_UNITS-1:0] ready;
	word_t block_q;
	key_t key_q;
	rounds_t rounds_q;
	word_t start_q;

	for (genvar g = 0; g < `CSA_UNITS; g++) begin : g_port
		assign ready[g] = job[g].job_ready;
		assign job[g].job_valid = offer_q && (ptr_q == unit_idx_t'(g));
		assign job[g].block = block_q;
		assign job[g].key = key_q;
		assign job[g].rounds = rounds_q;
		assign job[g].start = start_q;
	end

	// Offer only after the unit at the pointer is seen idle.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
			offer_q <= 1'b0;
			ptr_q <= '0;
		end else if (offer_q) begin
			offer_q <= 1'b0;
			pending_q <= 1'b0;
			ptr_q <= (ptr_q == unit_idx_t'(`CSA_UNITS - 1)) ? '0 : ptr_q + 1'b1;
		end else if (pending_q) begin
			offer_q <= ready[ptr_q];
		end else begin
			pending_q <= submit_i;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (submit_i && !pending_q) begin
			block_q <= block_i;
			key_q <= key_i;
			rounds_q <= rounds_i;
			start_q <= start_i;
		end
	end

	assign pending_o = pending_q;

endmodule

// ==== logic/csa_calc_unit.sv ====
`timescale 1ns/1ps

module csa_calc_unit (
	input logic axi_mm_clk,
	input logic rst_n,
	csa_job_if.unit job,
	csa_result_if.unit res,
	output logic active_o
);
	import csa_pkg::*;

	calc_state_t state_q;
	logic take;
	key_t st_q;
	key_t key_q;
	key_t mixed;
	rounds_t left_q;
	word_t cnt_q;
	word_t start_q;

	assign take = job.job_valid && (state_q == CALC_IDLE);

	// Rotate left by 5, fold in the key, add the round counter to the low word.
	always_comb begin
		mixed = {st_q[58:0], st_q[63:59]} ^ key_q;
		mixed[31:0] = mixed[31:0] + cnt_q;
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= CALC_IDLE;
		end else begin
			case (state_q)
				CALC_IDLE: if (take) state_q <= CALC_RUN;
				CALC_RUN: if (left_q == '0) state_q <= CALC_DONE;
				CALC_DONE: if (res.res_ack) state_q <= CALC_IDLE;
				default: state_q <= CALC_IDLE;
			endcase
		end
	end

	// First round adds the start value itself.
	always_ff @(posedge axi_mm_clk) begin
		if (take) begin
			st_q <= job.key ^ {32'd0, job.block};
			key_q <= job.key;
			left_q <= job.rounds;
			cnt_q <= job.start;
			start_q <= job.start;
		end else if (state_q == CALC_RUN && left_q != '0) begin
			st_q <= mixed;
			left_q <= left_q - 1'b1;
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign job.job_ready = (state_q == CALC_IDLE);
	assign res.res_valid = (state_q == CALC_DONE);
	assign res.result = st_q;
	assign res.start = start_q;
	assign active_o = (state_q != CALC_IDLE);

endmodule

// ==== logic/csa_collect.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_collect (
	input logic axi_mm_clk,
	input logic rst_n,
	csa_result_if.collect res [0:`CSA_UNITS-1],
	csa_status_if.collect status,
	output logic waiting_o
);
	import csa_pkg::*;

	unit_idx_t idx_q;
	logic ack_q;
	logic upd_q;
	logic grab;
	logic hit;
	logic [`CSA_UNITS-1:0] valid;
	key_t result_v [`CSA_UNITS];
	word_t start_v [`CSA_UNITS];
	key_t res_q;
	word_t start_q;
	hist_idx_t bin;
	count_t hist_q [`CSA_HIST_BINS];
	count_t match_q;
	logic snap_valid_q;
	key_t snap_result_q;
	word_t snap_start_q;

	for (genvar g = 0; g < `CSA_UNITS; g++) begin : g_port
		assign valid[g] = res[g].res_valid;
		assign result_v[g] = res[g].result;
		assign start_v[g] = res[g].start;
		assign res[g].res_ack = ack_q && (idx_q == unit_idx_t'(g));
	end

	assign grab = !ack_q && !upd_q && valid[idx_q];
	assign bin = res_q[3:0];
	assign hit = ((res_q ^ status.value) & status.mask) == '0;

	// Ack cycle, then update cycle, then on to the next unit.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			idx_q <= '0;
			ack_q <= 1'b0;
			upd_q <= 1'b0;
			snap_valid_q <= 1'b0;
			match_q <= '0;
		end else begin
			ack_q <= grab;
			upd_q <= ack_q;
			if (upd_q) begin
				idx_q <= (idx_q == unit_idx_t'(`CSA_UNITS - 1)) ? '0 : idx_q + 1'b1;
				if (idx_q == status.channel)
					snap_valid_q <= 1'b1;
			end
			if (status.channel_wr)
				snap_valid_q <= 1'b0;
			if (status.clear)
				match_q <= '0;
			else if (upd_q && hit)
				match_q <= match_q + 1'b1;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (grab) begin
			res_q <= result_v[idx_q];
			start_q <= start_v[idx_q];
		end
		if (upd_q && idx_q == status.channel) begin
			snap_result_q <= res_q;
			snap_start_q <= start_q;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n || status.clear) begin
			for (int i = 0; i < `CSA_HIST_BINS; i++)
				hist_q[i] <= '0;
		end else if (upd_q) begin
			hist_q[bin] <= hist_q[bin] + 1'b1;
		end
	end

	assign status.snap_valid = snap_valid_q;
	assign status.snap_result = snap_result_q;
	assign status.snap_start = snap_start_q;
	assign status.hist_count = hist_q[status.hist_index];
	assign status.match_count = match_q;
	assign waiting_o = ack_q || upd_q;

endmodule

// ==== logic/csa_top.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_top (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [`CSA_ADDR_BITS-1:0] wb_adr_i,
	input csa_pkg::word_t wb_dat_i,
	output csa_pkg::word_t wb_dat_o,
	output logic wb_ack_o
);
	import csa_pkg::*;

	word_t job_block;
	key_t job_key;
	rounds_t job_rounds;
	word_t job_start;
	logic submit;
	logic pending;
	logic waiting;
	logic busy;
	logic [`CSA_UNITS-1:0] active;

	csa_job_if job_bus [0:`CSA_UNITS-1] ();
	csa_result_if res_bus [0:`CSA_UNITS-1] ();
	csa_status_if status ();

	// Idle only when nothing is queued, computing or being drained.
	assign busy = pending || (|active) || waiting;

	csa_regs u_regs (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.job_block_o(job_block),
		.job_key_o(job_key),
		.job_rounds_o(job_rounds),
		.job_start_o(job_start),
		.submit_o(submit),
		.pending_i(pending),
		.busy_i(busy),
		.status(status)
	);

	csa_dispatch u_dispatch (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.submit_i(submit),
		.block_i(job_block),
		.key_i(job_key),
		.rounds_i(job_rounds),
		.start_i(job_start),
		.pending_o(pending),
		.job(job_bus)
	);

	for (genvar g = 0; g < `CSA_UNITS; g++) begin : g_unit
		csa_calc_unit u_unit (
			.axi_mm_clk(axi_mm_clk),
			.rst_n(rst_n),
			.job(job_bus[g]),
			.res(res_bus[g]),
			.active_o(active[g])
		);
	end

	csa_collect u_collect (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.res(res_bus),
		.status(status),
		.waiting_o(waiting)
	);

endmodule

// ==== verif/csa_checker.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_checker (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wb_ack_o,
	input logic offer_i,
	input csa_pkg::unit_idx_t offer_idx_i,
	input logic [`CSA_UNITS-1:0] ready_i,
	input logic [`CSA_UNITS-1:0] res_valid_i,
	input logic res_ack_i,
	input csa_pkg::unit_idx_t drain_idx_i
);
	import csa_pkg::*;

	// One ack per strobe.
	ack_single: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		wb_ack_o |=> !wb_ack_o)
		else $error("Wishbone ack held longer than one cycle");

	// Job handoff goes only to an idle unit.
	offer_ready: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		offer_i |-> ready_i[offer_idx_i])
		else $error("job_valid raised toward a unit that is not ready");

	for (genvar g = 0; g < `CSA_UNITS; g++) begin : g_hold
		res_hold: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
			res_valid_i[g] && !(res_ack_i && drain_idx_i == unit_idx_t'(g)) |=> res_valid_i[g])
			else $error("res_valid dropped before res_ack on unit %0d", g);
	end

endmodule

bind csa_top csa_checker u_checker (
	.axi_mm_clk(axi_mm_clk),
	.rst_n(rst_n),
	.wb_ack_o(wb_ack_o),
	.offer_i(u_dispatch.offer_q),
	.offer_idx_i(u_dispatch.ptr_q),
	.ready_i(u_dispatch.ready),
	.res_valid_i(u_collect.valid),
	.res_ack_i(u_collect.ack_q),
	.drain_idx_i(u_collect.idx_q)
);

// ==== verif/csa_tb.sv ====
`timescale 1ns/1ps
`include "csa_settings.svh"

module csa_tb;
	import csa_pkg::*;

	localparam int ACK_LIMIT = 50;
	localparam int POLL_LIMIT = 200;

	logic axi_mm_clk = 1'b0;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`CSA_ADDR_BITS-1:0] wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;

	integer seed;
	int checks;
	int errors;
	int timeouts;
	count_t hist_exp [`CSA_HIST_BINS];
	count_t match_exp;
	key_t mask;
	key_t value;

	csa_top dut (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack)
	);

	always #20 axi_mm_clk = ~axi_mm_clk;

	// Keyed mixing rule, one round per loop pass.
	function automatic key_t mix_ref(word_t block, key_t key, rounds_t rounds, word_t start);
		key_t st;
		st = key ^ {32'd0, block};
		for (int r = 0; r < int'(rounds); r++) begin
			st = ((st << 5) | (st >> 59)) ^ key;
			st[31:0] = st[31:0] + start + word_t'(r);
		end
		return st;
	endfunction

	task automatic stop_on_timeout(string what);
		timeouts++;
		$display("Timeout: %s did not complete by %0t ns", what, $time);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(negedge axi_mm_clk);
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		if (!wb_ack)
			stop_on_timeout("Wishbone ack");
	endtask

	task automatic wb_write(logic [`CSA_ADDR_BITS-1:0] adr, word_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		wait_ack();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(logic [`CSA_ADDR_BITS-1:0] adr, output word_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack();
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic check_key(key_t got, key_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(count_t got, count_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_word(word_t got, word_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_idle();
		word_t busy;
		int n;
		n = 0;
		busy = 32'd1;
		while (busy[0] && n < POLL_LIMIT) begin
			wb_read(`CSA_REG_BUSY, busy);
			n++;
		end
		if (busy[0])
			stop_on_timeout("BUSY poll");
	endtask

	task automatic read_result(output key_t res);
		word_t lo;
		word_t hi;
		wb_read(`CSA_REG_RES_LO, lo);
		wb_read(`CSA_REG_RES_HI, hi);
		res = {hi, lo};
	endtask

	// Runs one job and books its expected effect on histogram and matches.
	task automatic run_job(word_t blk, key_t key, rounds_t rnd, word_t st, output key_t exp);
		exp = mix_ref(blk, key, rnd, st);
		wb_write(`CSA_REG_BLOCK, blk);
		wb_write(`CSA_REG_KEY_LO, key[31:0]);
		wb_write(`CSA_REG_KEY_HI, key[63:32]);
		wb_write(`CSA_REG_ROUNDS, word_t'(rnd));
		wb_write(`CSA_REG_START, st);
		wb_write(`CSA_REG_SUBMIT, 32'd1);
		wait_idle();
		hist_exp[exp[3:0]]++;
		if ((exp & mask) == (value & mask))
			match_exp++;
	endtask

	task automatic check_bins(string what, output count_t sum);
		word_t rd;
		sum = '0;
		for (int i = 0; i < `CSA_HIST_BINS; i++) begin
			wb_write(`CSA_REG_HIST_INDEX, word_t'(i));
			wb_read(`CSA_REG_HIST_COUNT, rd);
			check_count(rd, hist_exp[i], $sformatf("%s bin %0d", what, i));
			sum += rd;
		end
	endtask

	initial begin
		word_t rd;
		key_t got;
		key_t exp;
		word_t blk;
		key_t key;
		rounds_t rnd;
		word_t st;
		count_t sum;
		seed = 41625;
		checks = 0;
		errors = 0;
		timeouts = 0;
		match_exp = '0;
		for (int i = 0; i < `CSA_HIST_BINS; i++)
			hist_exp[i] = '0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (8) @(negedge axi_mm_clk);
		rst_n = 1'b1;
		@(negedge axi_mm_clk);

		wb_read(`CSA_REG_RES_VALID, rd);
		check_word(rd, 32'd0, "RES_VALID after reset");
		wb_read(`CSA_REG_MATCH_COUNT, rd);
		check_count(rd, 32'd0, "MATCH_COUNT after reset");
		check_bins("reset", sum);
		wb_read(`CSA_REG_BUSY, rd);
		check_word(rd, 32'd0, "BUSY after reset");

		mask = 64'h0000_0100_0000_0003;
		value = 64'h0000_0100_0000_0001;
		wb_write(`CSA_REG_MASK_LO, mask[31:0]);
		wb_write(`CSA_REG_MASK_HI, mask[63:32]);
		wb_write(`CSA_REG_VALUE_LO, value[31:0]);
		wb_write(`CSA_REG_VALUE_HI, value[63:32]);

		// Channel stays 0, so every fourth job is snapshotted.
		for (int i = 0; i < 16; i++) begin
			blk = $random(seed);
			key = {$random(seed), $random(seed)};
			rnd = rounds_t'($random(seed)) & 8'h1f;
			st = $random(seed);
			run_job(blk, key, rnd, st, exp);
			if (i % `CSA_UNITS == 0) begin
				read_result(got);
				check_key(got, exp, $sformatf("result of job %0d", i));
				wb_read(`CSA_REG_RES_START, rd);
				check_word(rd, st, $sformatf("start of job %0d", i));
			end
		end
		check_bins("batch", sum);
		check_count(sum, 32'd16, "histogram total");
		wb_read(`CSA_REG_MATCH_COUNT, rd);
		check_count(rd, match_exp, "MATCH_COUNT after batch");

		wb_write(`CSA_REG_CHANNEL, 32'd7);
		wb_read(`CSA_REG_CHANNEL, rd);
		check_word(rd, 32'd0, "CHANNEL after write of 7");
		wb_read(5'd25, rd);
		check_word(rd, 32'hE000_0019, "unmapped read");
		wb_write(`CSA_REG_CLEAR, 32'd1);
		match_exp = '0;
		for (int i = 0; i < `CSA_HIST_BINS; i++)
			hist_exp[i] = '0;
		check_bins("clear", sum);
		wb_read(`CSA_REG_MATCH_COUNT, rd);
		check_count(rd, 32'd0, "MATCH_COUNT after clear");

		// Zero rounds gives back key XOR block.
		blk = $random(seed);
		key = {$random(seed), $random(seed)};
		st = $random(seed);
		run_job(blk, key, 8'd0, st, exp);
		read_result(got);
		check_key(got, key ^ {32'd0, blk}, "zero-round result");
		wb_read(`CSA_REG_RES_VALID, rd);
		check_word(rd, 32'd1, "RES_VALID after zero-round job");

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
logic/csa_pkg.sv
logic/csa_ifs.sv
logic/csa_regs.sv
logic/csa_dispatch.sv
logic/csa_calc_unit.sv
logic/csa_collect.sv
logic/csa_top.sv
verif/csa_checker.sv
verif/csa_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= csa_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
